//--- hdl/lc3IsaPkg.sv
package lc3IsaPkg;

    typedef logic [15:0] word_t;    // data and address word
    typedef logic [2:0]  regIdx_t;  // r0..r7
    typedef logic [2:0]  nzp_t;     // [2]=N [1]=Z [0]=P

    // full opcode map, unsupported ones named so decode can list them
    typedef enum logic [3:0] {
        opBr   = 4'b0000,
        opAdd  = 4'b0001,
        opLd   = 4'b0010,
        opSt   = 4'b0011,
        opJsr  = 4'b0100, // not implemented
        opAnd  = 4'b0101,
        opLdr  = 4'b0110,
        opStr  = 4'b0111,
        opRti  = 4'b1000, // not implemented
        opNot  = 4'b1001,
        opLdi  = 4'b1010, // not implemented
        opSti  = 4'b1011, // not implemented
        opJmp  = 4'b1100, // also RET with base r7
        opRes  = 4'b1101, // reserved
        opLea  = 4'b1110,
        opTrap = 4'b1111  // not implemented
    } opcode_t;

    // sign extend the low width bits of field, upper bits ignored
    function automatic word_t sext(input word_t field, input int unsigned width);
        word_t shifted;
        shifted = field << (16 - width); // move sign bit to bit 15
        return word_t'($signed(shifted) >>> (16 - width));
    endfunction

    // condition codes for a value written to a register
    function automatic nzp_t flagsOf(input word_t value);
        if (value[15])
            return 3'b100;
        else if (value == '0)
            return 3'b010;
        return 3'b001;
    endfunction

endpackage

//--- hdl/lc3CtrlPkg.sv
package lc3CtrlPkg;

    import lc3IsaPkg::*;

    // sequencer states, numbering kept contiguous
    typedef enum logic [4:0] {
        start,
        fetch0, fetch1, fetch2,
        decode,
        alu0, br0, jmp0, lea0,
        ld0, ld1, ld2,
        ldr0, ldr1, ldr2,
        st0, st1, st2,
        str0, str1, str2
    } ctrlState_t;

    // who drives the internal bus
    typedef enum logic [2:0] {busNone, busPc, busEa, busMdr, busAlu} busSrc_t;

    typedef enum logic [1:0] {aluPass, aluAdd, aluAnd, aluNot} aluOp_t;

    // second adder input of the EA adder, off11 unused without JSR
    typedef enum logic [1:0] {offZero, off6, off9, off11} addr2Sel_t;

    typedef struct packed {
        busSrc_t   busSrc;
        aluOp_t    aluOp;
        regIdx_t   sr1;          // ALU A and EA base
        regIdx_t   sr2;          // ALU B in register form
        regIdx_t   dr;
        logic      pcFromEa;     // PC mux: EA, else PC+1
        logic      addr1FromReg; // EA base: sr1, else PC
        addr2Sel_t addr2Sel;
        logic      regWe;
        logic      flagWe;
        logic      ldPc;
        logic      ldIr;
        logic      ldMar;
        logic      ldMdr;
        logic      mdrFromMem;   // MDR source: memory, else bus
        logic      memWe;
    } ctrlWord_t;

    // nothing loads, nothing on the bus
    localparam ctrlWord_t ctrlIdle = '{
        busSrc:   busNone,
        aluOp:    aluPass,
        sr1:      '0,
        sr2:      '0,
        dr:       '0,
        addr2Sel: offZero,
        default:  1'b0
    };

endpackage

//--- hdl/lc3Control.sv
`timescale 1ns/100ps

module lc3Control
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  word_t     ir,
    input  nzp_t      nzp,
    output ctrlWord_t ctrl,
    output logic      memWe
);

    ctrlState_t state;
    ctrlState_t nextState;
    ctrlState_t decodeTarget;
    opcode_t    opcode;
    logic       brTaken;

    assign opcode  = opcode_t'(ir[15:12]);
    assign brTaken = |(ir[11:9] & nzp); // any requested flag set
    assign memWe   = ctrl.memWe;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= start;
        else
            state <= nextState;
    end

    // execute entry point per opcode
    always_comb
    begin
        decodeTarget = fetch0;
        case (opcode)
            opAdd, opAnd, opNot: decodeTarget = alu0;
            opBr:  decodeTarget = br0;
            opJmp: decodeTarget = jmp0;
            opLea: decodeTarget = lea0;
            opLd:  decodeTarget = ld0;
            opLdr: decodeTarget = ldr0;
            opSt:  decodeTarget = st0;
            opStr: decodeTarget = str0;
            opJsr, opRti, opLdi, opSti, opRes, opTrap: decodeTarget = fetch0; // no-op
        endcase
    end

    always_comb
    begin
        case (state)
            fetch0: nextState = fetch1;
            fetch1: nextState = fetch2;
            fetch2: nextState = decode;
            decode: nextState = decodeTarget;
            ld0:    nextState = ld1;
            ld1:    nextState = ld2;
            ldr0:   nextState = ldr1;
            ldr1:   nextState = ldr2;
            st0:    nextState = st1;
            st1:    nextState = st2;
            str0:   nextState = str1;
            str1:   nextState = str2;
            default: nextState = fetch0; // start and every last execute state
        endcase
    end

    // control word, purely from state and IR
    always_comb
    begin
        ctrl = ctrlIdle;
        case (state)
            fetch0:
            begin
                ctrl.busSrc = busPc; // MAR <- PC
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;  // PC <- PC+1
            end
            fetch1, ld1, ldr1:
            begin
                ctrl.ldMdr      = 1'b1;
                ctrl.mdrFromMem = 1'b1;
            end
            fetch2:
            begin
                ctrl.busSrc = busMdr;
                ctrl.ldIr   = 1'b1;
            end
            alu0:
            begin
                ctrl.busSrc = busAlu;
                ctrl.sr1    = ir[8:6];
                ctrl.sr2    = ir[2:0];
                ctrl.dr     = ir[11:9];
                ctrl.regWe  = 1'b1;
                ctrl.flagWe = 1'b1;
                case (opcode)
                    opAdd:   ctrl.aluOp = aluAdd;
                    opAnd:   ctrl.aluOp = aluAnd;
                    opNot:   ctrl.aluOp = aluNot;
                    default: ctrl.aluOp = aluPass;
                endcase
            end
            br0:
            begin
                ctrl.addr2Sel = off9;     // PC-relative target
                ctrl.pcFromEa = 1'b1;
                ctrl.ldPc     = brTaken;
            end
            jmp0:
            begin
                ctrl.sr1          = ir[8:6];
                ctrl.addr1FromReg = 1'b1; // base + 0
                ctrl.pcFromEa     = 1'b1;
                ctrl.ldPc         = 1'b1;
            end
            lea0:
            begin
                ctrl.busSrc   = busEa;
                ctrl.addr2Sel = off9;
                ctrl.dr       = ir[11:9];
                ctrl.regWe    = 1'b1;
                ctrl.flagWe   = 1'b1;
            end
            ld0, st0:
            begin
                ctrl.busSrc   = busEa;
                ctrl.addr2Sel = off9;
                ctrl.ldMar    = 1'b1;
            end
            ldr0, str0:
            begin
                ctrl.busSrc       = busEa;
                ctrl.sr1          = ir[8:6];
                ctrl.addr1FromReg = 1'b1;
                ctrl.addr2Sel     = off6;
                ctrl.ldMar        = 1'b1;
            end
            ld2, ldr2:
            begin
                ctrl.busSrc = busMdr;
                ctrl.dr     = ir[11:9];
                ctrl.regWe  = 1'b1;
                ctrl.flagWe = 1'b1;
            end
            st1, str1:
            begin
                ctrl.busSrc = busAlu; // source reg passes through ALU
                ctrl.sr1    = ir[11:9];
                ctrl.ldMdr  = 1'b1;
            end
            st2, str2: ctrl.memWe = 1'b1;
            default: ;
        endcase
    end

    // a write strobe always closes a full store sequence
    assert property (@(posedge clk) disable iff (reset)
        memWe |-> state inside {st2, str2} && $past(state, 2) inside {st0, str0});

    assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && state <= str2);

endmodule

//--- hdl/lc3RegFile.sv
`timescale 1ns/100ps

module lc3RegFile
    import lc3IsaPkg::*;
(
    input  logic            clk,
    input  logic            reset,
    input  regIdx_t         sr1,
    input  regIdx_t         sr2,
    input  regIdx_t         dr,
    input  logic            we,
    input  word_t           wData,
    output word_t           rData1,
    output word_t           rData2,
    output word_t [7:0]     regView
);

    word_t [7:0] regs; // r7 at the top

    // single write port, written from the bus
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            regs <= '0;
        else if (we)
            regs[dr] <= wData;
    end

    // combinational reads, old value seen during a write cycle
    assign rData1 = regs[sr1];
    assign rData2 = regs[sr2];

    assign regView = regs; // observation port

endmodule

//--- hdl/lc3Datapath.sv
`timescale 1ns/100ps

module lc3Datapath
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;
#(
    parameter word_t resetPc = 16'h3000
)(
    input  logic        clk,
    input  logic        reset,
    input  ctrlWord_t   ctrl,
    input  word_t       mdr,
    output word_t       bus,
    output word_t       ir,
    output nzp_t        nzp,
    output word_t       pc,
    output word_t [7:0] regView
);

    word_t rData1;
    word_t rData2;
    word_t aluB;
    word_t aluOut;
    word_t addr1;
    word_t addr2;
    word_t ea;
    word_t pcNext;

    lc3RegFile regFile0 (
        .clk     (clk),
        .reset   (reset),
        .sr1     (ctrl.sr1),
        .sr2     (ctrl.sr2),
        .dr      (ctrl.dr),
        .we      (ctrl.regWe),
        .wData   (bus),
        .rData1  (rData1),
        .rData2  (rData2),
        .regView (regView)
    );

    // ALU with imm5 form when IR[5] set
    assign aluB = ir[5] ? sext(ir, 5) : rData2;

    always_comb
    begin
        case (ctrl.aluOp)
            aluAdd:  aluOut = rData1 + aluB;
            aluAnd:  aluOut = rData1 & aluB;
            aluNot:  aluOut = ~rData1;
            default: aluOut = rData1; // pass for stores
        endcase
    end

    // effective address adder
    assign addr1 = ctrl.addr1FromReg ? rData1 : pc;

    always_comb
    begin
        case (ctrl.addr2Sel)
            off6:    addr2 = sext(ir, 6);
            off9:    addr2 = sext(ir, 9);
            off11:   addr2 = sext(ir, 11);
            default: addr2 = '0;
        endcase
    end

    assign ea = addr1 + addr2;

    // bus mux
    always_comb
    begin
        case (ctrl.busSrc)
            busPc:   bus = pc;
            busEa:   bus = ea;
            busMdr:  bus = mdr;
            busAlu:  bus = aluOut;
            default: bus = '0; // idle bus
        endcase
    end

    assign pcNext = ctrl.pcFromEa ? ea : pc + 16'd1;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pc  <= resetPc;
            ir  <= '0;
            nzp <= '0; // no flag set until first write
        end
        else
        begin
            if (ctrl.ldPc)
                pc <= pcNext;
            if (ctrl.ldIr)
                ir <= bus;
            if (ctrl.flagWe)
                nzp <= flagsOf(bus);
        end
    end

    assert property (@(posedge clk) disable iff (reset) $onehot0(nzp));

endmodule

//--- hdl/lc3MemPort.sv
`timescale 1ns/100ps

module lc3MemPort
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  ctrlWord_t ctrl,
    input  word_t     bus,
    input  word_t     memRData,
    output word_t     memAddr,   // MAR
    output word_t     memWData   // MDR
);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            memAddr  <= '0;
            memWData <= '0;
        end
        else
        begin
            if (ctrl.ldMar)
                memAddr <= bus;
            if (ctrl.ldMdr)
                memWData <= ctrl.mdrFromMem ? memRData : bus; // read data or store data
        end
    end

    // store data is staged in MDR the cycle before the strobe
    assert property (@(posedge clk) disable iff (reset)
        ctrl.memWe |-> $past(ctrl.ldMdr) && !$past(ctrl.mdrFromMem));

endmodule

//--- hdl/lc3Core.sv
`timescale 1ns/100ps

module lc3Core
    import lc3IsaPkg::*;
    import lc3CtrlPkg::*;
#(
    parameter word_t resetPc = 16'h3000
)(
    input  logic        clk,
    input  logic        reset,
    input  word_t       memRData,
    output word_t       memAddr,
    output word_t       memWData,
    output logic        memWe,
    output word_t       pc,
    output word_t [7:0] regView,
    output nzp_t        nzp
);

    ctrlWord_t ctrl;
    word_t     ir;
    word_t     bus;

    lc3Control control0 (
        .clk   (clk),
        .reset (reset),
        .ir    (ir),
        .nzp   (nzp),
        .ctrl  (ctrl),
        .memWe (memWe)
    );

    lc3Datapath #(
        .resetPc (resetPc)
    ) datapath0 (
        .clk     (clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .mdr     (memWData), // MDR feeds busMdr
        .bus     (bus),
        .ir      (ir),
        .nzp     (nzp),
        .pc      (pc),
        .regView (regView)
    );

    lc3MemPort memPort0 (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .bus      (bus),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData)
    );

endmodule

//--- include/lc3RefModel.svh
`ifndef LC3_REF_MODEL_SVH
`define LC3_REF_MODEL_SVH

// architectural state of the instruction-level model
typedef struct packed {
    lc3IsaPkg::word_t       pc;
    lc3IsaPkg::word_t [7:0] regs;
    lc3IsaPkg::nzp_t        nzp;
} refState_t;

// one memory write per instruction at most
typedef struct packed {
    logic             valid;
    lc3IsaPkg::word_t addr;
    lc3IsaPkg::word_t data;
} refWrite_t;

// copy bit width-1 into every bit above it
function automatic lc3IsaPkg::word_t signExtend(input lc3IsaPkg::word_t value,
                                                input int width);
    lc3IsaPkg::word_t result;
    int               i;
    result = value;
    for (i = width; i < 16; i++)
        result[i] = value[width - 1];
    return result;
endfunction

// N Z P for a value written to a register
function automatic lc3IsaPkg::nzp_t conditionCodes(input lc3IsaPkg::word_t value);
    lc3IsaPkg::nzp_t cc;
    cc[2] = value[15];                         // negative
    cc[1] = (value == 16'h0000);               // zero
    cc[0] = !value[15] && (value != 16'h0000); // positive
    return cc;
endfunction

task automatic resetModel(ref refState_t s, input lc3IsaPkg::word_t resetPc);
    s    = '0;
    s.pc = resetPc;
endtask

// run one instruction and return its cycle count and any store
task automatic stepModel(ref refState_t s, ref lc3IsaPkg::word_t mem [65536],
                         output int cycles, output refWrite_t wr);
    lc3IsaPkg::word_t inst;
    lc3IsaPkg::word_t base;
    lc3IsaPkg::word_t opB;
    lc3IsaPkg::word_t res;
    logic             wb;
    logic             taken;
    inst   = mem[s.pc];
    s.pc   = s.pc + 16'd1; // PC+1 before execute
    cycles = 4;            // fetch and decode
    wr     = '0;
    wb     = 1'b0;
    res    = '0;
    base   = s.regs[inst[8:6]];
    opB    = inst[5] ? signExtend(inst, 5) : s.regs[inst[2:0]];
    case (lc3IsaPkg::opcode_t'(inst[15:12]))
        lc3IsaPkg::opAdd:
        begin
            res = base + opB;
            wb  = 1'b1;
            cycles += 1;
        end
        lc3IsaPkg::opAnd:
        begin
            res = base & opB;
            wb  = 1'b1;
            cycles += 1;
        end
        lc3IsaPkg::opNot:
        begin
            res = ~base;
            wb  = 1'b1;
            cycles += 1;
        end
        lc3IsaPkg::opBr:
        begin
            taken = (inst[11] && s.nzp[2]) || (inst[10] && s.nzp[1])
                    || (inst[9] && s.nzp[0]);
            if (taken)
                s.pc = s.pc + signExtend(inst, 9);
            cycles += 1;
        end
        lc3IsaPkg::opJmp:
        begin
            s.pc = base;
            cycles += 1;
        end
        lc3IsaPkg::opLea:
        begin
            res = s.pc + signExtend(inst, 9);
            wb  = 1'b1;
            cycles += 1;
        end
        lc3IsaPkg::opLd:
        begin
            res = mem[s.pc + signExtend(inst, 9)];
            wb  = 1'b1;
            cycles += 3;
        end
        lc3IsaPkg::opLdr:
        begin
            res = mem[base + signExtend(inst, 6)];
            wb  = 1'b1;
            cycles += 3;
        end
        lc3IsaPkg::opSt:
        begin
            wr.valid = 1'b1;
            wr.addr  = s.pc + signExtend(inst, 9);
            wr.data  = s.regs[inst[11:9]];
            mem[wr.addr] = wr.data;
            cycles += 3;
        end
        lc3IsaPkg::opStr:
        begin
            wr.valid = 1'b1;
            wr.addr  = base + signExtend(inst, 6);
            wr.data  = s.regs[inst[11:9]];
            mem[wr.addr] = wr.data;
            cycles += 3;
        end
        default: ; // unsupported opcodes fall back to fetch
    endcase
    if (wb)
    begin
        s.regs[inst[11:9]] = res;
        s.nzp = conditionCodes(res);
    end
endtask

`endif

//--- verif/lc3Tb.sv
`timescale 1ns/100ps

module lc3Tb
    import lc3IsaPkg::*;
();

    localparam word_t resetPc    = 16'h3000;
    localparam int    numInstr   = 2000;
    localparam int    edgeLimit  = 8;           // longest instruction is 7 cycles
    localparam int    driveDelay = 1;           // ns after the rising edge

    logic        clk;
    logic        reset;
    word_t       memRData;
    word_t       memAddr;
    word_t       memWData;
    logic        memWe;
    word_t       pc;
    word_t [7:0] regView;
    nzp_t        nzp;

    word_t mem [65536];      // memory seen by the DUT
    word_t refMem [65536];   // private copy for the model
    word_t wrAddrLog [$];    // stores seen on the memory port
    word_t wrDataLog [$];
    int    opCount [16];

    `include "lc3RefModel.svh"

    refState_t model;
    refWrite_t wr;
    int        cycles;
    word_t     inst;

    lc3Core #(
        .resetPc (resetPc)
    ) dut0 (
        .clk      (clk),
        .reset    (reset),
        .memRData (memRData),
        .memAddr  (memAddr),
        .memWData (memWData),
        .memWe    (memWe),
        .pc       (pc),
        .regView  (regView),
        .nzp      (nzp)
    );

    always #20 clk = ~clk;

    assign memRData = mem[memAddr]; // combinational read of MAR

    // write port samples the old MAR and MDR at the edge
    always @(posedge clk)
    begin
        if (!reset && memWe)
        begin
            mem[memAddr] <= memWData;
            wrAddrLog.push_back(memAddr);
            wrDataLog.push_back(memWData);
        end
    end

    // any opcode with offsets kept near the base
    function automatic word_t randomInstr();
        word_t w;
        w = word_t'($urandom);
        w[15:12] = 4'($urandom_range(0, 15));
        case (opcode_t'(w[15:12]))
            opBr:  w[8:0] = 9'($urandom_range(0, 15));            // forward only
            opLd, opSt: w[8:0] = 9'($urandom_range(0, 63)) - 9'd32;
            opLea: w[8:0] = 9'($urandom_range(0, 63));
            opAdd, opAnd:
                if (!w[5])
                    w[4:3] = 2'b00;                                // register form
            opNot: w[5:0] = 6'h3f;
            opJmp:
            begin
                w[11:9] = 3'b000;
                w[5:0]  = 6'h00;
            end
            default: ;
        endcase
        return w;
    endfunction

    task automatic reportMismatch(input string what);
        $display("FAIL %0t: %s", $time, what);
        $display("Some tests failed");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run aborted");
    endtask

    // n rising edges then step past the edge to sample
    task automatic waitEdges(input int n);
        int waited;
        for (waited = 0; waited < n; waited++)
        begin
            if (waited >= edgeLimit)
                abortRun($sformatf("timeout: instruction still busy after %0d cycles", waited));
            @(posedge clk);
        end
        #driveDelay;
    endtask

    task automatic compareState(input int idx);
        assert (pc === model.pc)
            else reportMismatch($sformatf("instr %0d pc %h, expected %h", idx, pc, model.pc));
        assert (regView === model.regs)
            else reportMismatch($sformatf("instr %0d regs %h, expected %h",
                                          idx, regView, model.regs));
        assert (nzp === model.nzp)
            else reportMismatch($sformatf("instr %0d nzp %b, expected %b", idx, nzp, model.nzp));
        assert (memWe === 1'b0)
            else reportMismatch($sformatf("instr %0d memWe high at boundary", idx));
        if (wr.valid)
        begin
            assert (wrAddrLog.size() == 1)
                else reportMismatch($sformatf("instr %0d saw %0d writes, expected 1",
                                              idx, wrAddrLog.size()));
            assert (wrAddrLog[0] === wr.addr && wrDataLog[0] === wr.data)
                else reportMismatch($sformatf("instr %0d wrote %h to %h, expected %h to %h",
                                              idx, wrDataLog[0], wrAddrLog[0], wr.data, wr.addr));
        end
        else
            assert (wrAddrLog.size() == 0)
                else reportMismatch($sformatf("instr %0d unexpected memory write", idx));
        wrAddrLog.delete();
        wrDataLog.delete();
    endtask

    initial
    begin
        int k;
        void'($urandom(32'hb3f0b0d5));
        clk   = 1'b0;
        reset = 1'b1;
        for (k = 0; k < 65536; k++)
            mem[word_t'(resetPc + k)] = randomInstr(); // whole space wrapping past 16'hffff
        refMem = mem;
        resetModel(model, resetPc);

        waitEdges(2);
        assert (memWe === 1'b0 && pc === resetPc && regView === '0 && nzp === '0)
            else reportMismatch($sformatf("reset state pc %h nzp %b memWe %b", pc, nzp, memWe));
        reset = 1'b0;
        waitEdges(1); // start state

        for (k = 0; k < numInstr; k++)
        begin
            inst = refMem[model.pc];
            opCount[inst[15:12]]++;
            stepModel(model, refMem, cycles, wr);
            waitEdges(cycles);
            compareState(k);
        end

        for (k = 0; k < 16; k++)
            $display("opcode %b executed %0d times", 4'(k), opCount[k]);
        $display("All tests passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
hdl/lc3IsaPkg.sv
hdl/lc3CtrlPkg.sv
hdl/lc3Control.sv
hdl/lc3RegFile.sv
hdl/lc3Datapath.sv
hdl/lc3MemPort.sv
hdl/lc3Core.sv
verif/lc3Tb.sv

//--- Bender.yml
package:
  name: lc3core

sources:
  - files:
      - hdl/lc3IsaPkg.sv
      - hdl/lc3CtrlPkg.sv
      - hdl/lc3Control.sv
      - hdl/lc3RegFile.sv
      - hdl/lc3Datapath.sv
      - hdl/lc3MemPort.sv
      - hdl/lc3Core.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/lc3Tb.sv
